// ==== flist.f ====
hw/cpuPkg.sv
hw/alu.sv
hw/regFile.sv
hw/controlFsm.sv
hw/microController.sv
hw/dataPath.sv
hw/multiCycleCpu.sv
verification/tbMultiCycleCpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbMultiCycleCpu
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tbMultiCycleCpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbMultiCycleCpu;

    localparam logic [31:0] ResetPc = 32'h0000_0100;
    localparam int TimeoutCycles = 3000;
    localparam logic [6:0] OpArith = 7'h33;
    localparam logic [6:0] OpImm = 7'h13;
    localparam logic [6:0] OpLoad = 7'h03;

    logic        clk = 1'b0;
    logic        arstN;
    logic        memReq;
    logic        memWe;
    logic        memRspValid;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [31:0] memRdata;

    logic [31:0] mem [0:511];
    logic [31:0] progQ [$];
    logic [31:0] reqAddrQ [$];
    logic        reqWeQ [$];
    logic [31:0] reqDataQ [$];
    logic [31:0] storeAddrQ [$];
    logic [31:0] storeDataQ [$];
    logic [31:0] expAddrQ [$];
    logic [31:0] expDataQ [$];
    logic [31:0] haltPc;
    logic [31:0] firstAddr;
    logic        firstWe;
    logic        firstSeen;
    logic        haltSeen;
    logic [31:0] lfsr = 32'h846c4380;
    int          valueErrors = 0;
    int          protocolErrors = 0;
    int          timeouts = 0;

    always #10 clk = ~clk;

    multiCycleCpu #(
        .ResetPc (ResetPc)
    ) i_multiCycleCpu (
        .clk         (clk),
        .arstN       (arstN),
        .memReq      (memReq),
        .memWe       (memWe),
        .memAddr     (memAddr),
        .memWdata    (memWdata),
        .memRspValid (memRspValid),
        .memRdata    (memRdata)
    );

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawDelay(output int d);
        logic [2:0] pick;
        pick = 3'd0;
        for (int k = 0; k < 3; k++) begin
            lfsr = lfsrNext(lfsr);
            pick = {pick[1:0], lfsr[0]};
        end
        d = int'(pick) + 1;
    endtask

    // Memory with one response per request after 1 to 8 cycles.
    initial begin : memoryModel
        int          countdown;
        logic [31:0] addr;
        countdown = 0;
        memRspValid = 1'b0;
        memRdata = 32'd0;
        firstSeen = 1'b0;
        haltSeen = 1'b0;
        firstAddr = 32'd0;
        firstWe = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            memRspValid = 1'b0;
            memRdata = 32'd0;
            if (!arstN) begin
                countdown = 0;
                reqAddrQ.delete();
                reqWeQ.delete();
                reqDataQ.delete();
                storeAddrQ.delete();
                storeDataQ.delete();
                firstSeen = 1'b0;
                haltSeen = 1'b0;
            end else if (countdown > 0) begin
                countdown--;
                if (countdown == 0) begin
                    addr = reqAddrQ.pop_front();
                    memRspValid = 1'b1;
                    if (reqWeQ.pop_front()) begin
                        storeAddrQ.push_back(addr);
                        storeDataQ.push_back(reqDataQ.pop_front());
                    end else begin
                        memRdata = mem[addr[10:2]];
                        void'(reqDataQ.pop_front());
                    end
                    if (reqAddrQ.size() > 0) begin
                        drawDelay(countdown);
                    end
                end
            end
            @(negedge clk);
            if (memReq && !arstN) begin
                $display("Memory request raised during reset at %0t ns", $time);
                protocolErrors++;
            end else if (memReq) begin
                if (reqAddrQ.size() > 0) begin
                    $display("Second memory request at %0t ns before the previous response",
                             $time);
                    protocolErrors++;
                end
                if (!firstSeen) begin
                    firstSeen = 1'b1;
                    firstAddr = memAddr;
                    firstWe = memWe;
                end
                if (!memWe && memAddr == haltPc) begin
                    haltSeen = 1'b1;
                end
                reqAddrQ.push_back(memAddr);
                reqWeQ.push_back(memWe);
                reqDataQ.push_back(memWdata);
                if (countdown == 0) begin
                    drawDelay(countdown);
                end
            end
        end
    end

    task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkAddr(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is address %h, expected %h", $time, what, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            valueErrors++;
        end
    endtask

    function automatic logic [31:0] rInstr(input int f3, input int f7, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OpArith};
    endfunction

    function automatic logic [31:0] iInstr(input logic [6:0] op, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] sInstr(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] bInstr(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] expectedAlu(input logic [2:0] f3, input logic [31:0] a,
                                                input logic [31:0] b, input logic sub);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    // Instruction-level model, records the stores it expects.
    task automatic runModel();
        logic [31:0] x [0:31];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] nextPc;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            x[i] = 32'd0;
        end
        expAddrQ.delete();
        expDataQ.delete();
        pc = ResetPc;
        steps = 0;
        while (pc != haltPc && steps < 2000) begin
            ins = mem[pc[10:2]];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            nextPc = pc + 32'd4;
            wr = 1'b0;
            res = 32'd0;
            case (ins[6:0])
                7'h33: begin
                    wr = 1'b1;
                    res = expectedAlu(ins[14:12], a, b, ins[30]);
                end
                7'h13: begin
                    wr = 1'b1;
                    res = expectedAlu(ins[14:12], a, immI, 1'b0);
                end
                7'h03: begin
                    wr = 1'b1;
                    addr = a + immI;
                    res = mem[addr[10:2]];
                end
                7'h23: begin
                    expAddrQ.push_back(a + immS);
                    expDataQ.push_back(b);
                end
                7'h63: begin
                    if (ins[12] ? (a != b) : (a == b)) begin
                        nextPc = pc + immB;
                    end
                end
                default: begin
                end
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
            end
            pc = nextPc;
            steps++;
        end
    endtask

    task automatic prepareImage();
        for (int i = 0; i < 512; i++) begin
            // Low bits are 00, never a valid opcode.
            mem[i] = 32'hC3C3_0000 ^ (i << 2);
        end
        progQ.delete();
    endtask

    task automatic putWord(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[10:2]] = data;
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        arstN = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;
        @(negedge clk);
        checkFlag(memReq, 1'b0, "memReq in the first cycle after reset");
    endtask

    task automatic waitForHalt(input string name);
        int cycles;
        cycles = 0;
        while (!haltSeen && cycles < TimeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (!haltSeen) begin
            $display("Timeout in %s: the program never reached its final loop", name);
            timeouts++;
        end
    endtask

    task automatic runProgram(input string name);
        int n;
        haltPc = ResetPc + 4 * progQ.size();
        for (int k = 0; k < progQ.size(); k++) begin
            putWord(ResetPc + 4 * k, progQ[k]);
        end
        // Final loop is a branch to itself.
        putWord(haltPc, bInstr(0, 0, 0, 0));
        runModel();
        applyReset();
        waitForHalt(name);
        checkAddr(firstAddr, ResetPc, {name, ": first fetch"});
        checkFlag(firstWe, 1'b0, {name, ": write flag of first request"});
        checkCount(storeAddrQ.size(), expAddrQ.size(), {name, ": number of stores"});
        n = (storeAddrQ.size() < expAddrQ.size()) ? storeAddrQ.size() : expAddrQ.size();
        for (int k = 0; k < n; k++) begin
            checkAddr(storeAddrQ[k], expAddrQ[k], $sformatf("%s: store %0d", name, k));
            checkWord(storeDataQ[k], expDataQ[k], $sformatf("%s: store %0d data", name, k));
        end
    endtask

    task automatic testRType();
        prepareImage();
        putWord(32'h600, 32'h0000_7F31);
        putWord(32'h604, 32'hFFFF_F00C);
        progQ.push_back(iInstr(OpImm, 0, 1, 0, 'h600));
        progQ.push_back(iInstr(OpLoad, 2, 2, 1, 0));
        progQ.push_back(iInstr(OpLoad, 2, 3, 1, 4));
        progQ.push_back(rInstr(0, 'h00, 4, 2, 3));
        progQ.push_back(rInstr(0, 'h20, 5, 2, 3));
        progQ.push_back(rInstr(7, 'h00, 6, 2, 3));
        progQ.push_back(rInstr(6, 'h00, 7, 2, 3));
        progQ.push_back(rInstr(2, 'h00, 8, 2, 3));
        progQ.push_back(rInstr(2, 'h00, 9, 3, 2));
        for (int r = 4; r < 10; r++) begin
            progQ.push_back(sInstr(r, 1, 'h100 + 4 * (r - 4)));
        end
        runProgram("R-type");
    endtask

    task automatic testImmediate();
        prepareImage();
        putWord(32'h608, 32'h1234_5678);
        progQ.push_back(iInstr(OpImm, 0, 1, 0, 'h600));
        progQ.push_back(iInstr(OpLoad, 2, 2, 1, 8));
        progQ.push_back(iInstr(OpImm, 0, 3, 2, -5));
        progQ.push_back(iInstr(OpImm, 7, 4, 2, 'h0F0));
        progQ.push_back(iInstr(OpImm, 6, 5, 2, -256));
        progQ.push_back(iInstr(OpImm, 7, 6, 2, -1));
        progQ.push_back(iInstr(OpImm, 0, 7, 0, -2048));
        progQ.push_back(iInstr(OpImm, 0, 0, 2, 7));
        for (int r = 3; r < 8; r++) begin
            progQ.push_back(sInstr(r, 1, 'h120 + 4 * (r - 3)));
        end
        progQ.push_back(sInstr(0, 1, 'h140));
        runProgram("immediate");
    endtask

    task automatic testLoadStore();
        prepareImage();
        putWord(32'h600, 32'h8000_0001);
        putWord(32'h604, 32'h7FFF_FFFE);
        putWord(32'h60C, 32'h0F1E_2D3C);
        progQ.push_back(iInstr(OpImm, 0, 10, 0, 'h740));
        progQ.push_back(iInstr(OpImm, 0, 11, 0, 'h610));
        progQ.push_back(iInstr(OpLoad, 2, 2, 11, -16));
        progQ.push_back(iInstr(OpLoad, 2, 3, 11, -12));
        progQ.push_back(iInstr(OpLoad, 2, 4, 11, -4));
        progQ.push_back(iInstr(OpLoad, 2, 5, 11, 0));
        progQ.push_back(sInstr(2, 10, -4));
        progQ.push_back(sInstr(3, 10, 16));
        progQ.push_back(sInstr(4, 10, -64));
        progQ.push_back(sInstr(5, 10, -2048));
        progQ.push_back(sInstr(2, 10, 2044));
        runProgram("load/store");
    endtask

    task automatic testBranches();
        prepareImage();
        progQ.push_back(iInstr(OpImm, 0, 1, 0, 5));
        progQ.push_back(iInstr(OpImm, 0, 2, 0, 0));
        progQ.push_back(iInstr(OpImm, 0, 10, 0, 'h700));
        // Countdown loop, three instructions.
        progQ.push_back(iInstr(OpImm, 0, 2, 2, 3));
        progQ.push_back(iInstr(OpImm, 0, 1, 1, -1));
        progQ.push_back(bInstr(1, 1, 0, -8));
        progQ.push_back(sInstr(2, 10, 0));
        progQ.push_back(sInstr(1, 10, 4));
        progQ.push_back(bInstr(0, 2, 0, 8));
        progQ.push_back(iInstr(OpImm, 0, 3, 0, 'h55));
        progQ.push_back(bInstr(0, 0, 0, 8));
        progQ.push_back(iInstr(OpImm, 0, 3, 0, 'h77));
        progQ.push_back(sInstr(3, 10, 8));
        progQ.push_back(bInstr(1, 0, 0, 8));
        progQ.push_back(iInstr(OpImm, 0, 4, 0, 'h11));
        progQ.push_back(sInstr(4, 10, 12));
        runProgram("branches");
    endtask

    initial begin
        arstN = 1'b0;
        haltPc = ResetPc;
        testRType();
        testImmediate();
        testLoadStore();
        testBranches();
        // Same program again under a new delay sequence.
        testRType();
        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 valueErrors, protocolErrors, timeouts);
        if (valueErrors + protocolErrors + timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/multiCycleCpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module multiCycleCpu #(
    parameter logic [31:0] ResetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arstN,
    output logic        memReq,
    output logic        memWe,
    output logic [31:0] memAddr,
    output logic [31:0] memWdata,
    input  logic        memRspValid,
    input  logic [31:0] memRdata
);
    import cpuPkg::*;

    stateT      state;
    opcodeT     opcode;
    logic [2:0] funct3;
    logic       pcWrite;
    logic       pcWriteCond;
    logic       pcWriteNotCond;
    logic       iOrD;
    logic       memToReg;
    logic       irWrite;
    logic       pcSource;
    aluOpT      aluOp;
    logic       aluSrcA;
    aluSrcBT    aluSrcB;
    logic       regWrite;

    controlFsm i_controlFsm (
        .clk         (clk),
        .arstN       (arstN),
        .opcode      (opcode),
        .memRspValid (memRspValid),
        .state       (state),
        .memReq      (memReq)
    );

    // Write flag goes straight to the memory port.
    microController i_microController (
        .state          (state),
        .opcode         (opcode),
        .funct3         (funct3),
        .pcWrite        (pcWrite),
        .pcWriteCond    (pcWriteCond),
        .pcWriteNotCond (pcWriteNotCond),
        .iOrD           (iOrD),
        .memWrite       (memWe),
        .memToReg       (memToReg),
        .irWrite        (irWrite),
        .pcSource       (pcSource),
        .aluOp          (aluOp),
        .aluSrcA        (aluSrcA),
        .aluSrcB        (aluSrcB),
        .regWrite       (regWrite)
    );

    dataPath #(
        .ResetPc (ResetPc)
    ) i_dataPath (
        .clk            (clk),
        .arstN          (arstN),
        .pcWrite        (pcWrite),
        .pcWriteCond    (pcWriteCond),
        .pcWriteNotCond (pcWriteNotCond),
        .iOrD           (iOrD),
        .memToReg       (memToReg),
        .irWrite        (irWrite),
        .pcSource       (pcSource),
        .aluOp          (aluOp),
        .aluSrcA        (aluSrcA),
        .aluSrcB        (aluSrcB),
        .regWrite       (regWrite),
        .memRspValid    (memRspValid),
        .memRdata       (memRdata),
        .memAddr        (memAddr),
        .memWdata       (memWdata),
        .opcode         (opcode),
        .funct3         (funct3)
    );

endmodule

`default_nettype wire

// ==== hw/dataPath.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataPath #(
    parameter logic [31:0] ResetPc = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic            pcWrite,
    input  logic            pcWriteCond,
    input  logic            pcWriteNotCond,
    input  logic            iOrD,
    input  logic            memToReg,
    input  logic            irWrite,
    input  logic            pcSource,
    input  cpuPkg::aluOpT   aluOp,
    input  logic            aluSrcA,
    input  cpuPkg::aluSrcBT aluSrcB,
    input  logic            regWrite,
    input  logic            memRspValid,
    input  logic [31:0]     memRdata,
    output logic [31:0]     memAddr,
    output logic [31:0]     memWdata,
    output cpuPkg::opcodeT  opcode,
    output logic [2:0]      funct3
);
    import cpuPkg::*;

    instrT       ir;
    logic [31:0] pc;
    logic [31:0] oldPc;
    logic [31:0] mdr;
    logic [31:0] regA;
    logic [31:0] regB;
    logic [31:0] aluOut;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] imm;
    logic [31:0] pcBase;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] aluResult;
    logic        zero;
    logic        pcEn;

    assign opcode = ir.rType.opcode;
    assign funct3 = ir.rType.funct3;

    always_comb begin
        case (ir.rType.opcode)
            OP_STORE: imm = {{20{ir.sType.imm11_5[6]}}, ir.sType.imm11_5, ir.sType.imm4_0};
            OP_BRANCH: imm = {{19{ir.bType.imm12}}, ir.bType.imm12, ir.bType.imm11,
                              ir.bType.imm10_5, ir.bType.imm4_1, 1'b0};
            default:  imm = {{20{ir.iType.imm11_0[11]}}, ir.iType.imm11_0};
        endcase
    end

    // Branch target is relative to the fetch address.
    assign pcBase = (aluSrcB == SRCB_FOUR) ? pc : oldPc;
    assign srcA   = aluSrcA ? regA : pcBase;

    always_comb begin
        case (aluSrcB)
            SRCB_FOUR: srcB = 32'd4;
            SRCB_IMM:  srcB = imm;
            default:   srcB = regB;
        endcase
    end

    alu i_alu (
        .aluOp    (aluOp),
        .funct3   (ir.rType.funct3),
        .funct7b5 (ir.rType.funct7[5]),
        .a        (srcA),
        .b        (srcB),
        .result   (aluResult),
        .zero     (zero)
    );

    regFile i_regFile (
        .clk    (clk),
        .arstN  (arstN),
        .we     (regWrite),
        .rs1    (ir.rType.rs1),
        .rs2    (ir.rType.rs2),
        .rd     (ir.rType.rd),
        .wdata  (memToReg ? mdr : aluOut),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign pcEn = (pcWrite && memRspValid) || (pcWriteCond && zero) || (pcWriteNotCond && !zero);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= ResetPc;
            ir <= '0;
        end else begin
            if (pcEn) pc <= pcSource ? aluOut : aluResult;
            if (irWrite && memRspValid) ir <= memRdata;
        end
    end

    always_ff @(posedge clk) begin
        regA   <= rdata1;
        regB   <= rdata2;
        aluOut <= aluResult;
        if (memRspValid) mdr <= memRdata;
        if (irWrite && memRspValid) oldPc <= pc;
    end

    assign memAddr  = iOrD ? aluOut : pc;
    assign memWdata = regB;

    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule

`default_nettype wire

// ==== hw/microController.sv ====
`timescale 1ns/10ps
`default_nettype none

module microController (
    input  cpuPkg::stateT   state,
    input  cpuPkg::opcodeT  opcode,
    input  logic [2:0]      funct3,
    output logic            pcWrite,
    output logic            pcWriteCond,
    output logic            pcWriteNotCond,
    output logic            iOrD,
    output logic            memWrite,
    output logic            memToReg,
    output logic            irWrite,
    output logic            pcSource,
    output cpuPkg::aluOpT   aluOp,
    output logic            aluSrcA,
    output cpuPkg::aluSrcBT aluSrcB,
    output logic            regWrite
);
    import cpuPkg::*;

    always_comb begin
        pcWrite        = 1'b0;
        pcWriteCond    = 1'b0;
        pcWriteNotCond = 1'b0;
        iOrD           = 1'b0;
        memWrite       = 1'b0;
        memToReg       = 1'b0;
        irWrite        = 1'b0;
        pcSource       = 1'b0;
        aluOp          = ALU_ADD;
        aluSrcA        = 1'b0;
        aluSrcB        = SRCB_REG;
        regWrite       = 1'b0;
        case (state)
            FETCH_WAIT: begin
                // Gated by the response in the datapath.
                aluSrcB = SRCB_FOUR;
                pcWrite = 1'b1;
                irWrite = 1'b1;
            end
            DECODE: begin
                aluSrcB = SRCB_IMM;
            end
            EXECUTE, MEM_REQ, MEM_WAIT, WRITEBACK: begin
                // Operands stay selected after execute so ALUOut holds.
                case (opcode)
                    OP_ARITH: begin
                        aluSrcA = 1'b1;
                        aluOp   = ALU_FUNCT;
                        aluSrcB = SRCB_REG;
                    end
                    OP_ARITH_IMM: begin
                        aluSrcA = 1'b1;
                        aluOp   = ALU_FUNCT_IMM;
                        aluSrcB = SRCB_IMM;
                    end
                    OP_LOAD, OP_STORE: begin
                        aluSrcA = 1'b1;
                        aluOp   = ALU_ADD;
                        aluSrcB = SRCB_IMM;
                    end
                    OP_BRANCH: begin
                        aluSrcA  = 1'b1;
                        aluOp    = ALU_SUB;
                        aluSrcB  = SRCB_REG;
                        pcSource = 1'b1;
                    end
                    default: begin
                    end
                endcase
                if (state == EXECUTE && opcode == OP_BRANCH) begin
                    pcWriteCond    = (funct3 == 3'b000);
                    pcWriteNotCond = (funct3 == 3'b001);
                end
                if (state == MEM_REQ || state == MEM_WAIT) begin
                    iOrD     = 1'b1;
                    memWrite = (opcode == OP_STORE);
                end
                if (state == WRITEBACK) begin
                    regWrite = 1'b1;
                    memToReg = (opcode == OP_LOAD);
                end
            end
            default: begin
            end
        endcase
    end

    // Only beq and bne are decoded.
    always_comb begin
        if (state == EXECUTE && opcode == OP_BRANCH) begin
            pcEnOneHot: assert ($onehot({pcWrite, pcWriteCond, pcWriteNotCond}))
                else $error("branch funct3 %b selects no single PC write", funct3);
        end
    end

endmodule

`default_nettype wire

// ==== hw/controlFsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlFsm (
    input  logic           clk,
    input  logic           arstN,
    input  cpuPkg::opcodeT opcode,
    input  logic           memRspValid,
    output cpuPkg::stateT  state,
    output logic           memReq
);
    import cpuPkg::*;

    stateT stateNext;
    logic  credit;
    logic  issue;

    assign issue = credit && ((state == FETCH_REQ) || (state == MEM_REQ));

    always_comb begin
        stateNext = state;
        case (state)
            FETCH_REQ:  if (credit) stateNext = FETCH_WAIT;
            FETCH_WAIT: if (memRspValid) stateNext = DECODE;
            DECODE:     stateNext = EXECUTE;
            EXECUTE: begin
                case (opcode)
                    OP_LOAD, OP_STORE:     stateNext = MEM_REQ;
                    OP_ARITH, OP_ARITH_IMM: stateNext = WRITEBACK;
                    default:               stateNext = FETCH_REQ;
                endcase
            end
            MEM_REQ:    if (credit) stateNext = MEM_WAIT;
            MEM_WAIT: begin
                // Stores retire on their response.
                if (memRspValid) begin
                    stateNext = (opcode == OP_LOAD) ? WRITEBACK : FETCH_REQ;
                end
            end
            default:    stateNext = FETCH_REQ;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= FETCH_REQ;
            memReq <= 1'b0;
            credit <= 1'b1;
        end else begin
            state  <= stateNext;
            memReq <= issue;
            // Request pulse spends the credit, the response brings it back.
            credit <= (credit && !memReq) || memRspValid;
        end
    end

    noRspWithCredit: assert property (@(posedge clk) disable iff (!arstN)
        memRspValid |-> !credit)
        else $error("memory response while the credit is held");

    reqNeedsCredit: assert property (@(posedge clk) disable iff (!arstN)
        memReq |-> credit)
        else $error("memory request without a credit");

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic        we,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // x0 is never written, so it reads back its reset value.
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    x0ReadsZero: assert property (@(posedge clk) disable iff (!arstN)
        ((rs1 != 5'd0) || (rdata1 == 32'd0)) && ((rs2 != 5'd0) || (rdata2 == 32'd0)))
        else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  cpuPkg::aluOpT aluOp,
    input  logic [2:0]    funct3,
    input  logic          funct7b5,
    input  logic [31:0]   a,
    input  logic [31:0]   b,
    output logic [31:0]   result,
    output logic          zero
);
    import cpuPkg::*;

    logic subSel;
    logic [31:0] sum;
    logic [31:0] diff;

    // Only register form uses funct7 to pick sub.
    assign subSel = (aluOp == ALU_FUNCT) && funct7b5;
    assign sum    = a + b;
    assign diff   = a - b;

    always_comb begin
        case (aluOp)
            ALU_ADD: result = sum;
            ALU_SUB: result = diff;
            default: begin
                case (funct3)
                    3'b000:  result = subSel ? diff : sum;
                    3'b010:  result = {31'd0, $signed(a) < $signed(b)};
                    3'b110:  result = a | b;
                    3'b111:  result = a & b;
                    default: result = sum;
                endcase
            end
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== hw/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    typedef enum logic [2:0] {
        FETCH_REQ  = 3'd0,
        FETCH_WAIT = 3'd1,
        DECODE     = 3'd2,
        EXECUTE    = 3'd3,
        MEM_REQ    = 3'd4,
        MEM_WAIT   = 3'd5,
        WRITEBACK  = 3'd6
    } stateT;

    // Base RV32I major opcodes.
    typedef enum logic [6:0] {
        OP_ARITH     = 7'b0110011,
        OP_ARITH_IMM = 7'b0010011,
        OP_LOAD      = 7'b0000011,
        OP_STORE     = 7'b0100011,
        OP_BRANCH    = 7'b1100011
    } opcodeT;

    // Immediate class keeps funct7 out of the decode.
    typedef enum logic [1:0] {
        ALU_ADD       = 2'b00,
        ALU_SUB       = 2'b01,
        ALU_FUNCT     = 2'b10,
        ALU_FUNCT_IMM = 2'b11
    } aluOpT;

    typedef enum logic [1:0] {
        SRCB_REG  = 2'b00,
        SRCB_FOUR = 2'b01,
        SRCB_IMM  = 2'b10
    } aluSrcBT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        opcodeT     opcode;
    } sTypeT;

    // Scrambled branch offset, bit 0 is implied zero.
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcodeT     opcode;
    } bTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
    } instrT;

endpackage

`default_nettype wire
